//--- verilog/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

   typedef logic [31:0] xlen_t;      // Data word and byte address
   typedef logic [31:0] inst_t;
   typedef logic [4:0]  reg_addr_t;

   // Major opcodes of the supported subset
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam inst_t NOP_INST = 32'h0000_0013;  // ADDI x0,x0,0

   // ALU_ADD must stay at zero so a cleared entry is a plain add
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B                     // LUI
   } alu_op_e;

   typedef struct packed {
      inst_t inst;
      xlen_t pc;
   } if_id_t;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      xlen_t     rs1_data;
      xlen_t     rs2_data;
      xlen_t     imm;
      reg_addr_t rd;
      alu_op_e   alu_op;
      logic      alu_src_imm;        // Operand B from imm
      logic      mem_read;
      logic      mem_write;
      logic      reg_write;
   } id_ex_t;

   typedef struct packed {
      xlen_t     alu_result;         // Also the memory address
      xlen_t     store_data;
      reg_addr_t rd;
      logic      mem_read;
      logic      mem_write;
      logic      reg_write;
   } ex_mem_t;

   typedef struct packed {
      logic      we;
      reg_addr_t rd;
      xlen_t     data;
   } wb_t;

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter riscv_pkg::xlen_t RESET_PC = '0
) (
   input  logic               clk,
   input  logic               arst_n_i,
   input  logic               stall_i,
   input  riscv_pkg::inst_t   inst_i,
   output riscv_pkg::xlen_t   inst_addr_o,
   output logic               inst_ce_o,
   output riscv_pkg::if_id_t  if_id_o
);

   import riscv_pkg::*;

   xlen_t  pc_q;
   logic   ce_q;
   if_id_t if_id_q;
   logic   advance;

   assign advance = ce_q & ~stall_i;  // Fetch accepted this cycle

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q         <= RESET_PC;
         ce_q         <= 1'b0;
         if_id_q.inst <= NOP_INST;
         if_id_q.pc   <= RESET_PC;
      end else begin
         ce_q <= 1'b1;                // Enabled from the first edge on
         if (advance) begin
            pc_q         <= pc_q + xlen_t'(4);
            if_id_q.inst <= inst_i;   // Word answered in the same cycle
            if_id_q.pc   <= pc_q;
         end
      end
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;
   assign if_id_o     = if_id_q;

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  riscv_pkg::if_id_t     if_id_i,
   input  riscv_pkg::xlen_t      rs1_data_i,
   input  riscv_pkg::xlen_t      rs2_data_i,
   output riscv_pkg::reg_addr_t  rs1_addr_o,
   output riscv_pkg::reg_addr_t  rs2_addr_o,
   output logic                  stall_o,
   output riscv_pkg::id_ex_t     id_ex_o
);

   import riscv_pkg::*;

   inst_t      inst;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_b5;
   reg_addr_t  rs1;
   reg_addr_t  rs2;
   xlen_t      imm_i;
   xlen_t      imm_s;
   xlen_t      imm_u;
   logic       valid;
   logic       load_use;
   id_ex_t     dec;
   id_ex_t     id_ex_q;

   assign inst      = if_id_i.inst;
   assign opcode    = inst[6:0];
   assign funct3    = inst[14:12];
   assign funct7_b5 = inst[30];     // SUB versus ADD
   assign rs1       = inst[19:15];
   assign rs2       = inst[24:20];

   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_u = {inst[31:12], 12'b0};

   always_comb begin
      dec          = '0;
      dec.rs1      = rs1;
      dec.rs2      = rs2;
      dec.rs1_data = rs1_data_i;
      dec.rs2_data = rs2_data_i;
      dec.rd       = inst[11:7];
      valid        = 1'b1;
      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            dec.reg_write   = 1'b1;
            dec.alu_src_imm = (opcode == OPC_OP_IMM);
            dec.imm         = imm_i;
            case (funct3)
               3'b000: begin
                  // Only register form has SUB
                  if (opcode == OPC_OP && funct7_b5)
                     dec.alu_op = ALU_SUB;
                  else
                     dec.alu_op = ALU_ADD;
               end
               3'b111: dec.alu_op = ALU_AND;
               3'b110: dec.alu_op = ALU_OR;
               3'b100: dec.alu_op = ALU_XOR;
               3'b010: begin
                  dec.alu_op = ALU_SLT;
                  valid      = (opcode == OPC_OP);  // No SLTI in subset
               end
               default: valid = 1'b0;
            endcase
         end
         OPC_LUI: begin
            dec.reg_write   = 1'b1;
            dec.alu_src_imm = 1'b1;
            dec.alu_op      = ALU_PASS_B;
            dec.imm         = imm_u;
         end
         OPC_LOAD: begin
            dec.reg_write   = 1'b1;
            dec.mem_read    = 1'b1;
            dec.alu_src_imm = 1'b1;
            dec.imm         = imm_i;
            valid           = (funct3 == 3'b010);   // LW only
         end
         OPC_STORE: begin
            dec.mem_write   = 1'b1;
            dec.alu_src_imm = 1'b1;
            dec.imm         = imm_s;
            valid           = (funct3 == 3'b010);   // SW only
         end
         default: valid = 1'b0;
      endcase
      if (!valid)
         dec = '0;                   // Unsupported word turns into a bubble
   end

   // Load in ID/EX feeding the instruction now in decode
   assign load_use = id_ex_q.mem_read && (id_ex_q.rd != '0) &&
                     ((id_ex_q.rd == rs1) || (id_ex_q.rd == rs2));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i)
         id_ex_q <= '0;
      else if (load_use)
         id_ex_q <= '0;              // One bubble, fetch holds
      else
         id_ex_q <= dec;
   end

   assign rs1_addr_o = rs1;
   assign rs2_addr_o = rs2;
   assign stall_o    = load_use;
   assign id_ex_o    = id_ex_q;

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  riscv_pkg::reg_addr_t  rs1_addr_i,
   input  riscv_pkg::reg_addr_t  rs2_addr_i,
   input  riscv_pkg::wb_t        wb_i,
   output riscv_pkg::xlen_t      rs1_data_o,
   output riscv_pkg::xlen_t      rs2_data_o
);

   import riscv_pkg::*;

   xlen_t regs_q [1:31];            // x0 has no storage

   // Write-through so decode sees this cycle's write-back
   function automatic xlen_t read_port(input reg_addr_t addr);
      xlen_t value;
      if (addr == '0)
         value = '0;
      else if (wb_i.we && (wb_i.rd == addr))
         value = wb_i.data;
      else
         value = regs_q[addr];
      return value;
   endfunction

   always_comb rs1_data_o = read_port(rs1_addr_i);
   always_comb rs2_data_o = read_port(rs2_addr_i);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < 32; i++)
            regs_q[i] <= '0;
      end else if (wb_i.we && (wb_i.rd != '0)) begin
         regs_q[wb_i.rd] <= wb_i.data;
      end
   end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  logic                clk,
   input  logic                arst_n_i,
   input  riscv_pkg::id_ex_t   id_ex_i,
   input  riscv_pkg::wb_t      wb_i,
   output riscv_pkg::ex_mem_t  ex_mem_o
);

   import riscv_pkg::*;

   ex_mem_t ex_mem_q;
   xlen_t   op_a;
   xlen_t   rs2_fwd;
   xlen_t   op_b;
   xlen_t   alu_result;

   // Newest producer wins, a load in EX/MEM has no result yet
   function automatic xlen_t forward(
      input reg_addr_t rs,
      input xlen_t     rf_data,
      input ex_mem_t   ex_mem,
      input wb_t       wb
   );
      xlen_t value;
      value = rf_data;
      if (rs != '0) begin
         if (ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.rd == rs))
            value = ex_mem.alu_result;
         else if (wb.we && (wb.rd == rs))
            value = wb.data;
      end
      return value;
   endfunction

   assign op_a    = forward(id_ex_i.rs1, id_ex_i.rs1_data, ex_mem_q, wb_i);
   assign rs2_fwd = forward(id_ex_i.rs2, id_ex_i.rs2_data, ex_mem_q, wb_i);
   assign op_b    = id_ex_i.alu_src_imm ? id_ex_i.imm : rs2_fwd;

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_ADD:    alu_result = op_a + op_b;
         ALU_SUB:    alu_result = op_a - op_b;
         ALU_AND:    alu_result = op_a & op_b;
         ALU_OR:     alu_result = op_a | op_b;
         ALU_XOR:    alu_result = op_a ^ op_b;
         ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_PASS_B: alu_result = op_b;
         default:    alu_result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ex_mem_q <= '0;
      end else begin
         ex_mem_q.alu_result <= alu_result;
         ex_mem_q.store_data <= rs2_fwd;   // Store data forwarded too
         ex_mem_q.rd         <= id_ex_i.rd;
         ex_mem_q.mem_read   <= id_ex_i.mem_read;
         ex_mem_q.mem_write  <= id_ex_i.mem_write;
         ex_mem_q.reg_write  <= id_ex_i.reg_write;
      end
   end

   assign ex_mem_o = ex_mem_q;

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
   input  logic                clk,
   input  logic                arst_n_i,
   input  riscv_pkg::ex_mem_t  ex_mem_i,
   input  riscv_pkg::xlen_t    data_i,
   output riscv_pkg::xlen_t    data_addr_o,
   output riscv_pkg::xlen_t    data_o,
   output logic                data_ce_o,
   output logic                data_we_o,
   output riscv_pkg::wb_t      wb_o
);

   import riscv_pkg::*;

   wb_t   wb_q;
   xlen_t result;

   // Data port straight from EX/MEM
   assign data_addr_o = ex_mem_i.alu_result;
   assign data_o      = ex_mem_i.store_data;
   assign data_ce_o   = ex_mem_i.mem_read | ex_mem_i.mem_write;
   assign data_we_o   = ex_mem_i.mem_write;

   // Load data arrives in the same cycle
   assign result = ex_mem_i.mem_read ? data_i : ex_mem_i.alu_result;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_q <= '0;
      end else begin
         wb_q.we   <= ex_mem_i.reg_write;
         wb_q.rd   <= ex_mem_i.rd;
         wb_q.data <= result;
      end
   end

   assign wb_o = wb_q;

endmodule

`default_nettype wire

//--- verilog/riscv.sv
`timescale 1ns/1ps
`default_nettype none

module riscv #(
   parameter riscv_pkg::xlen_t RESET_PC = '0
) (
   input  logic               clk,
   input  logic               arst_n_i,
   // Instruction port
   input  riscv_pkg::inst_t   inst_i,
   output riscv_pkg::xlen_t   inst_addr_o,
   output logic               inst_ce_o,
   // Data port
   input  riscv_pkg::xlen_t   data_i,
   output riscv_pkg::xlen_t   data_addr_o,
   output riscv_pkg::xlen_t   data_o,
   output logic               data_ce_o,
   output logic               data_we_o
);

   import riscv_pkg::*;

   logic      stall;
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   xlen_t     rs1_data;
   xlen_t     rs2_data;
   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   wb_t       wb;

   fetch_stage #(
      .RESET_PC (RESET_PC)
   ) i_fetch_stage (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .stall_i     (stall),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .if_id_o     (if_id)
   );

   decode_stage i_decode_stage (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .if_id_i    (if_id),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .rs1_addr_o (rs1_addr),
      .rs2_addr_o (rs2_addr),
      .stall_o    (stall),
      .id_ex_o    (id_ex)
   );

   reg_file i_reg_file (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .wb_i       (wb),          // Write port
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   execute_stage i_execute_stage (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .id_ex_i  (id_ex),
      .wb_i     (wb),            // Second forwarding source
      .ex_mem_o (ex_mem)
   );

   mem_wb_stage i_mem_wb_stage (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .ex_mem_i    (ex_mem),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o),
      .wb_o        (wb)
   );

endmodule

`default_nettype wire

//--- dv/riscv_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_assertions (
   input logic             clk,
   input logic             arst_n_i,
   input riscv_pkg::xlen_t inst_addr_i,
   input logic             inst_ce_i,
   input logic             data_ce_i,
   input logic             data_we_i
);

   // A store is always a data access
   a_we_needs_ce: assert property (
      @(posedge clk) disable iff (!arst_n_i) data_we_i |-> data_ce_i
   ) else $error("data_we_o high without data_ce_o");

   a_fetch_aligned: assert property (
      @(posedge clk) disable iff (!arst_n_i) inst_addr_i[1:0] == 2'b00
   ) else $error("inst_addr_o not word aligned: %h", inst_addr_i);

   // No fetch while held in reset
   a_no_fetch_in_reset: assert property (
      @(posedge clk) !arst_n_i |-> !inst_ce_i
   ) else $error("inst_ce_o high during reset");

endmodule

bind riscv riscv_assertions i_riscv_assertions (
   .clk         (clk),
   .arst_n_i    (arst_n_i),
   .inst_addr_i (inst_addr_o),
   .inst_ce_i   (inst_ce_o),
   .data_ce_i   (data_ce_o),
   .data_we_i   (data_we_o)
);

`default_nettype wire

//--- dv/tb_riscv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv;

   import riscv_pkg::*;

   localparam xlen_t RESET_PC = '0;
   localparam int    CLK_NS   = 20;
   localparam int    MAX_ROWS = 64;

   typedef struct packed {
      inst_t inst;
      logic  is_store;
      xlen_t addr;                   // Expected store address
      xlen_t data;                   // Expected store data
   } row_t;

   logic   clk;
   logic   arst_n_i;
   inst_t  inst_i;
   xlen_t  data_i;
   xlen_t  inst_addr_o;
   logic   inst_ce_o;
   xlen_t  data_addr_o;
   xlen_t  data_o;
   logic   data_ce_o;
   logic   data_we_o;

   row_t   prog [0:MAX_ROWS-1];
   int     store_rows [0:MAX_ROWS-1];  // Row index of each store in order
   inst_t  imem [0:MAX_ROWS-1];
   xlen_t  dmem [0:MAX_ROWS-1];
   int     prog_len = 0;
   int     n_stores = 0;
   int     store_ptr = 0;
   int     errors = 0;
   logic   table_ready = 1'b0;
   logic   fetch_started = 1'b0;
   xlen_t  prev_fetch;
   row_t   exp_row;
   integer seed = 62055;

   // Both memories answer in the same cycle
   assign inst_i = (inst_addr_o[31:2] < prog_len) ? imem[inst_addr_o[7:2]] : NOP_INST;
   assign data_i = data_ce_o ? dmem[data_addr_o[7:2]] : 'x;  // Undefined unless enabled

   riscv #(
      .RESET_PC (RESET_PC)
   ) i_riscv (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o)
   );

   function automatic inst_t enc_r(input logic [6:0] funct7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] funct3,
                                   input reg_addr_t rd);
      return {funct7, rs2, rs1, funct3, rd, OPC_OP};
   endfunction

   function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] funct3, input reg_addr_t rd,
                                   input logic [6:0] opcode);
      return {imm, rs1, funct3, rd, opcode};
   endfunction

   function automatic inst_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
   endfunction

   function automatic inst_t enc_u(input logic [19:0] imm, input reg_addr_t rd);
      return {imm, rd, OPC_LUI};
   endfunction

   // Initial data word mixing every address bit
   function automatic xlen_t mem_word(input xlen_t addr);
      return (addr * 32'h9E37_79B9) ^ 32'h5A5A_0000;
   endfunction

   task automatic add_row(input inst_t inst, input logic is_store, input xlen_t addr,
                          input xlen_t data);
      prog[prog_len] = '{inst: inst, is_store: is_store, addr: addr, data: data};
      if (is_store) begin
         store_rows[n_stores] = prog_len;
         n_stores++;
      end
      prog_len++;
   endtask

   task automatic add_inst(input inst_t inst);
      add_row(inst, 1'b0, '0, '0);
   endtask

   // SW rs2, addr(x0)
   task automatic add_store(input reg_addr_t rs2, input xlen_t addr, input xlen_t data);
      add_row(enc_s(addr[11:0], rs2, 5'd0), 1'b1, addr, data);
   endtask

   task automatic report_mismatch(input string name, input xlen_t got, input xlen_t expected);
      $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, expected);
      errors++;
   endtask

   task automatic finish_run();
      $display("Summary: %0d errors, %0d of %0d stores seen", errors, store_ptr, n_stores);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   endtask

   initial begin : build_program
      logic [31:0] rnd;
      logic [11:0] imm_a;
      logic [11:0] imm_b;
      logic [19:0] imm_u;
      xlen_t       va;
      xlen_t       vb;
      rnd   = $random(seed);
      imm_a = rnd[11:0] | 12'h800;    // Negative to exercise signed SLT
      rnd   = $random(seed);
      imm_b = rnd[11:0] & 12'h7FF;
      rnd   = $random(seed);
      imm_u = rnd[31:12];
      va    = {{20{imm_a[11]}}, imm_a};
      vb    = {{20{imm_b[11]}}, imm_b};
      add_inst(enc_i(imm_a, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      add_inst(enc_i(imm_b, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
      add_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));      // ADD from EX/MEM and MEM/WB
      add_store(5'd3, 32'd64, va + vb);
      add_inst(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));      // SUB
      add_store(5'd4, 32'd68, va - vb);
      add_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
      add_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
      add_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
      add_store(5'd5, 32'd72, va & vb);
      add_store(5'd6, 32'd76, va | vb);
      add_store(5'd7, 32'd80, va ^ vb);
      add_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));      // SLT both ways
      add_inst(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9));
      add_store(5'd8, 32'd84, 32'd1);                        // Negative x1 below positive x2
      add_store(5'd9, 32'd88, 32'd0);
      add_inst(enc_u(imm_u, 5'd10));
      add_store(5'd10, 32'd92, {imm_u, 12'h000});
      add_inst(enc_i(12'h0F0, 5'd1, 3'b111, 5'd11, OPC_OP_IMM));
      add_inst(enc_i(12'hF00, 5'd2, 3'b110, 5'd12, OPC_OP_IMM));
      add_inst(enc_i(12'h555, 5'd1, 3'b100, 5'd13, OPC_OP_IMM));
      add_store(5'd11, 32'd96, va & 32'h0000_00F0);
      add_store(5'd12, 32'd100, vb | 32'hFFFF_FF00);
      add_store(5'd13, 32'd104, va ^ 32'h0000_0555);
      add_inst(enc_i(12'd16, 5'd0, 3'b010, 5'd14, OPC_LOAD));  // Load-use on rs1
      add_inst(enc_i(12'd7, 5'd14, 3'b000, 5'd15, OPC_OP_IMM));
      add_store(5'd15, 32'd108, mem_word(32'd16) + 32'd7);
      add_inst(enc_i(12'd20, 5'd0, 3'b010, 5'd17, OPC_LOAD));  // Load-use on rs2
      add_store(5'd17, 32'd112, mem_word(32'd20));
      add_inst(enc_i(12'd5, 5'd0, 3'b000, 5'd0, OPC_OP_IMM));  // Write to x0 is dropped
      add_store(5'd0, 32'd116, 32'd0);
      add_inst(enc_i(12'd33, 5'd0, 3'b000, 5'd16, OPC_OP_IMM));
      add_inst(NOP_INST);
      add_inst(NOP_INST);
      add_store(5'd16, 32'd120, 32'd33);                     // Read through write-through
      for (int i = 0; i < MAX_ROWS; i++)
         dmem[i] = mem_word(i * 4);
      for (int i = 0; i < prog_len; i++)
         imem[i] = prog[i].inst;
      table_ready = 1'b1;
   end

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin : main
      arst_n_i = 1'b0;
      repeat (10) @(posedge clk);
      #2 arst_n_i = 1'b1;
      wait (table_ready && store_ptr >= n_stores);
      repeat (10) @(negedge clk);    // Drain to catch late stores
      if (store_ptr != n_stores) begin
         $display("ERROR: saw %0d stores, program has %0d", store_ptr, n_stores);
         errors++;
      end
      finish_run();
   end

   initial begin : watchdog
      wait (table_ready);
      #((prog_len * 2 + 40) * CLK_NS);
      $display("ERROR: watchdog expired, program did not finish");
      errors++;
      finish_run();
   end

   // Outputs are settled at the falling edge
   always @(negedge clk) begin
      if (!arst_n_i) begin
         if (inst_ce_o || data_ce_o || data_we_o) begin
            $display("ERROR: memory enable high during reset at t=%0t", $time);
            errors++;
         end
      end else begin
         if (inst_ce_o) begin
            if (!fetch_started && inst_addr_o !== RESET_PC)
               report_mismatch("inst_addr_o", inst_addr_o, RESET_PC);
            if (fetch_started && inst_addr_o !== prev_fetch &&
                inst_addr_o !== prev_fetch + 32'd4) begin
               $display("ERROR: fetch address jumped from %h to %h at t=%0t",
                        prev_fetch, inst_addr_o, $time);
               errors++;
            end
            fetch_started = 1'b1;
            prev_fetch    = inst_addr_o;
         end else if (fetch_started) begin
            $display("ERROR: inst_ce_o dropped after fetch started at t=%0t", $time);
            errors++;
         end
         if (data_we_o) begin
            if (store_ptr >= n_stores) begin
               $display("ERROR: store to %h beyond the program at t=%0t", data_addr_o, $time);
               errors++;
            end else begin
               exp_row = prog[store_rows[store_ptr]];
               if (data_addr_o !== exp_row.addr)
                  report_mismatch("data_addr_o", data_addr_o, exp_row.addr);
               if (data_o !== exp_row.data)
                  report_mismatch("data_o", data_o, exp_row.data);
            end
            store_ptr++;
            dmem[data_addr_o[7:2]] = data_o;
         end
      end
   end

endmodule

`default_nettype wire

//--- tb.f
verilog/riscv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv.sv
dv/riscv_assertions.sv
dv/tb_riscv.sv

//--- Bender.yml
package:
  name: riscv

sources:
  # Design
  - files:
      - verilog/riscv_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/decode_stage.sv
      - verilog/reg_file.sv
      - verilog/execute_stage.sv
      - verilog/mem_wb_stage.sv
      - verilog/riscv.sv

  # Verification
  - target: test
    files:
      - dv/riscv_assertions.sv
      - dv/tb_riscv.sv

# Top modules: riscv (design), tb_riscv (simulation)
